// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= edpTop.f
TB_TOP    ?= edpTb
RTL_TOP   ?= edpTop
TB_SRC    ?= edpTb.sv
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --assert
PASS_TEXT ?= Simulation completed successfully

RTL_SRCS := $(filter-out $(TB_SRC),$(shell cat $(FILELIST)))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

sim:
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR) -o $(TB_TOP)
	./$(BUILD_DIR)/$(TB_TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: edpAdder.sv
`timescale 1ns/10ps
`default_nettype none

module edpAdder import edpPkg::*; #(
  parameter int WIDTH = 36
) (
  input  logic [0:WIDTH-1] a,
  input  logic [0:WIDTH-1] b,
  input  adFuncT           func,
  input  logic             carryIn,
  output logic [0:WIDTH-1] sum,
  output logic             carryOut
);

  logic [0:WIDTH-1] bOperand;
  logic [WIDTH:0]   addResult;

  // Subtract works as A plus inverted B, the increment arrives on carryIn
  always_comb begin
    bOperand  = (func == fnSUB) ? ~b : b;
    addResult = {1'b0, a} + {1'b0, bOperand} + {{WIDTH{1'b0}}, carryIn};
  end

  always_comb begin
    carryOut = 1'b0;
    unique case (func)
      fnADD, fnSUB: begin
        sum      = addResult[WIDTH-1:0];
        carryOut = addResult[WIDTH];
      end
      fnAND: begin
        sum = a & b;
      end
      fnOR: begin
        sum = a | b;
      end
      fnXOR: begin
        sum = a ^ b;
      end
      fnPASSA: begin
        sum = a;
      end
      fnPASSB: begin
        sum = b;
      end
      fnZERO: begin
        sum = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: edpCtlIf.sv
`timescale 1ns/10ps
`default_nettype none

interface edpCtlIf import edpPkg::*, edpRegMapPkg::*; #(
  parameter int FM_ADR_W = 4
) ();

  // Steering from the register block
  microWordT           micro;
  logic [FM_ADR_W-1:0] fmAdr;
  word36               dataIn;
  logic                step;

  // Read-back from the datapath
  word36               diagWord;
  statusT              status;

  modport regs(output micro, fmAdr, dataIn, step, input diagWord, status);
  modport path(input micro, fmAdr, dataIn, step, output diagWord, status);

endinterface

`default_nettype wire

// File: edpDatapath.sv
`timescale 1ns/10ps
`default_nettype none

module edpDatapath import edpPkg::*, edpRegMapPkg::*; #(
  parameter int FM_ADR_W = 4
) (
  input logic   CLK,
  input logic   FPGA_RESET,
  edpCtlIf.path ctl
);

  word36 ar, arx, br, brx, mq;
  word36 fm;
  word36 arNext, arxNext;

  // AD carries two sign extension bits, -2 and -1
  word36        adAWord;
  logic [-2:35] adA, adB, ad;
  word36        adxA, adxB, adx;
  logic [0:19]  adHighSum;
  logic [0:17]  adLowSum;
  logic         adHighCin, adLowCin, adxCin;
  logic         adCarry, adLowCarry, adxCarry;
  logic         adOvf;
  logic         subMode;

  function automatic word36 regSource(regSrcT sel, word36 din, word36 adw,
                                      word36 adxw, word36 mqw);
    word36 v;
    unique case (sel)
      srcDATAIN: v = din;
      srcAD:     v = adw;
      srcADX:    v = adxw;
      srcMQ:     v = mqw;
    endcase
    return v;
  endfunction

  // A side
  always_comb begin
    unique case (ctl.micro.adaSel)
      adaAR:   adAWord = ar;
      adaARX:  adAWord = arx;
      adaMQ:   adAWord = mq;
      adaZERO: adAWord = '0;
    endcase
  end

  assign adA  = {{2{adAWord[0]}}, adAWord};
  assign adxA = (ctl.micro.adaSel == adaZERO) ? '0 : arx;

  // B side, the shifted forms fill from the low word
  always_comb begin
    unique case (ctl.micro.adbSel)
      adbFM:   adB = {{2{fm[0]}}, fm};
      adbBRX2: adB = {{2{br[0]}}, br[1:35], brx[0]};
      adbBR:   adB = {{2{br[0]}}, br};
      adbARX4: adB = {ar[0:1], ar[2:35], arx[0:1]};
    endcase
  end

  always_comb begin
    unique case (ctl.micro.adbSel)
      adbFM:   adxB = fm;
      adbBRX2: adxB = {brx[1:35], 1'b0};
      adbBR:   adxB = brx;
      adbARX4: adxB = {arx[2:35], 2'b00};
    endcase
  end

  // Subtract needs the +1 at the bottom of every independent chain
  assign subMode   = ctl.micro.adFunc == fnSUB;
  assign adxCin    = ctl.micro.adxCarryIn | subMode;
  assign adLowCin  = ctl.micro.adLong ? adxCarry : subMode;
  assign adHighCin = ctl.micro.inhCarry18 ? subMode : adLowCarry;

  edpAdder #(.WIDTH(20)) adHigh (
    .a(adA[-2:17]), .b(adB[-2:17]), .func(ctl.micro.adFunc),
    .carryIn(adHighCin), .sum(adHighSum), .carryOut(adCarry)
  );

  edpAdder #(.WIDTH(18)) adLow (
    .a(adA[18:35]), .b(adB[18:35]), .func(ctl.micro.adFunc),
    .carryIn(adLowCin), .sum(adLowSum), .carryOut(adLowCarry)
  );

  edpAdder #(.WIDTH(36)) adxUnit (
    .a(adxA), .b(adxB), .func(ctl.micro.adFunc),
    .carryIn(adxCin), .sum(adx), .carryOut(adxCarry)
  );

  assign ad    = {adHighSum, adLowSum};
  assign adOvf = (ad[-2] ^ ad[0]) | (ad[-1] ^ ad[0]);

  assign arNext  = regSource(ctl.micro.arSrc, ctl.dataIn, ad[0:35], adx, mq);
  assign arxNext = regSource(ctl.micro.arxSrc, ctl.dataIn, ad[0:35], adx, mq);

  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      ar  <= '0;
      arx <= '0;
      br  <= '0;
      brx <= '0;
      mq  <= '0;
    end else if (ctl.step) begin
      if (ctl.micro.arLoad) begin
        ar <= arNext;
      end
      if (ctl.micro.arxLoad) begin
        arx <= arxNext;
      end
      if (ctl.micro.brLoad) begin
        br <= ar;
      end
      if (ctl.micro.brxLoad) begin
        brx <= arx;
      end
      unique case (ctl.micro.mqFunc)
        mqHOLD: mq <= mq;
        mqLOAD: mq <= ad[0:35];
        mqSHL:  mq <= {mq[1:35], adCarry};
        mqSHR:  mq <= {mq[0], mq[0:34]};
      endcase
    end
  end

  edpFastMem #(.ADR_W(FM_ADR_W)) fastMem (
    .CLK(CLK),
    .adr(ctl.fmAdr),
    .din(ar),
    .weL(ctl.step && ctl.micro.fmWriteL),
    .weR(ctl.step && ctl.micro.fmWriteR),
    .dout(fm)
  );

  // Diagnostic read-back
  always_comb begin
    unique case (ctl.micro.diagSel)
      diagAR:  ctl.diagWord = ar;
      diagBR:  ctl.diagWord = br;
      diagMQ:  ctl.diagWord = mq;
      diagFM:  ctl.diagWord = fm;
      diagBRX: ctl.diagWord = brx;
      diagARX: ctl.diagWord = arx;
      diagADX: ctl.diagWord = adx;
      diagAD:  ctl.diagWord = ad[0:35];
    endcase
  end

  assign ctl.status = statusT'{adCarryOut: adCarry, adOverflow: adOvf, adxCarryOut: adxCarry};

  // The register block must never step while the datapath is in reset
  stepOutsideReset: assert property (@(posedge CLK) ctl.step |-> !FPGA_RESET);

endmodule

`default_nettype wire

// File: edpFastMem.sv
`timescale 1ns/10ps
`default_nettype none

module edpFastMem import edpPkg::*; #(
  parameter int ADR_W = 4
) (
  input  logic             CLK,
  input  logic [ADR_W-1:0] adr,
  input  word36            din,
  input  logic             weL,
  input  logic             weR,
  output word36            dout
);

  localparam int DEPTH = 2 ** ADR_W;

  // One array per halfword so each side writes on its own
  half18 memL [DEPTH];
  half18 memR [DEPTH];

  always_ff @(posedge CLK) begin
    if (weL) begin
      memL[adr] <= din[0:17];
    end
    if (weR) begin
      memR[adr] <= din[18:35];
    end
  end

  // Asynchronous read
  assign dout = {memL[adr], memR[adr]};

endmodule

`default_nettype wire

// File: edpPkg.sv
`default_nettype none

package edpPkg;

  // Bit 0 is the most significant bit, as on the real machine
  typedef logic [0:35] word36;
  typedef logic [0:17] half18;

  // Adder A source
  typedef enum logic [1:0] {
    adaAR,
    adaARX,
    adaMQ,
    adaZERO
  } adaSelT;

  // Adder B source, the shifted forms pull in bits of the low word
  typedef enum logic [1:0] {
    adbFM,
    adbBRX2,
    adbBR,
    adbARX4
  } adbSelT;

  typedef enum logic [2:0] {
    fnADD,
    fnSUB,
    fnAND,
    fnOR,
    fnXOR,
    fnPASSA,
    fnPASSB,
    fnZERO
  } adFuncT;

  // AR and ARX load source
  typedef enum logic [1:0] {
    srcDATAIN,
    srcAD,
    srcADX,
    srcMQ
  } regSrcT;

  // Zero code is HOLD so a cleared microword leaves MQ alone
  typedef enum logic [1:0] {
    mqHOLD,
    mqLOAD,
    mqSHL,
    mqSHR
  } mqFuncT;

  typedef enum logic [2:0] {
    diagAR,
    diagBR,
    diagMQ,
    diagFM,
    diagBRX,
    diagARX,
    diagADX,
    diagAD
  } diagSelT;

endpackage

`default_nettype wire

// File: edpRegBlock.sv
`timescale 1ns/10ps
`default_nettype none

module edpRegBlock import edpPkg::*, edpRegMapPkg::*; #(
  parameter int FM_ADR_W = 4
) (
  input  logic              CLK,
  input  logic              FPGA_RESET,
  input  logic              wbCyc,
  input  logic              wbStb,
  input  logic              wbWe,
  input  logic [ADDR_W-1:0] wbAdr,
  input  word36             wbDatW,
  output word36             wbDatR,
  output logic              wbAck,
  edpCtlIf.regs             ctl
);

  localparam int MICRO_W = $bits(microWordT);

  logic req;
  logic wrReq;
  logic rdReq;

  // No new request is taken while ack is still high
  assign req   = wbCyc && wbStb && !wbAck;
  assign wrReq = req && wbWe;
  assign rdReq = req && !wbWe;

  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      wbAck     <= 1'b0;
      ctl.step  <= 1'b0;
      ctl.micro <= '0;
      ctl.fmAdr <= '0;
    end else begin
      wbAck <= req;
      // Step lives for exactly the ack cycle
      ctl.step <= wrReq && (wbAdr == ADR_STEP);
      if (wrReq && (wbAdr == ADR_MICRO)) begin
        ctl.micro <= microWordT'(wbDatW[36-MICRO_W:35]);
      end
      if (wrReq && (wbAdr == ADR_FMADR)) begin
        ctl.fmAdr <= wbDatW[36-FM_ADR_W:35];
      end
    end
  end

  // Data-in word
  always_ff @(posedge CLK) begin
    if (wrReq && (wbAdr == ADR_DATAIN)) begin
      ctl.dataIn <= wbDatW;
    end
  end

  // Read data is captured at the edge that raises ack
  always_ff @(posedge CLK) begin
    if (rdReq) begin
      case (wbAdr)
        ADR_MICRO:  wbDatR <= word36'(ctl.micro);
        ADR_DATAIN: wbDatR <= ctl.dataIn;
        ADR_DIAG:   wbDatR <= ctl.diagWord;
        ADR_STATUS: wbDatR <= word36'(ctl.status);
        ADR_FMADR:  wbDatR <= word36'(ctl.fmAdr);
        default:    wbDatR <= '0;
      endcase
    end
  end

  // Ack answers a request seen on the previous edge
  ackFollowsReq: assert property (
    @(posedge CLK) disable iff (FPGA_RESET)
    wbAck |-> $past(wbCyc && wbStb)
  );

  // Single-cycle ack
  ackOneCycle: assert property (
    @(posedge CLK) disable iff (FPGA_RESET)
    wbAck |=> !wbAck
  );

endmodule

`default_nettype wire

// File: edpRegMapPkg.sv
`default_nettype none

package edpRegMapPkg;
  import edpPkg::*;

  localparam int ADDR_W = 4;

  // Word addresses on the host bus
  localparam logic [ADDR_W-1:0] ADR_MICRO  = 'h0;
  localparam logic [ADDR_W-1:0] ADR_DATAIN = 'h1;
  localparam logic [ADDR_W-1:0] ADR_STEP   = 'h2;
  localparam logic [ADDR_W-1:0] ADR_DIAG   = 'h3;
  localparam logic [ADDR_W-1:0] ADR_STATUS = 'h4;
  localparam logic [ADDR_W-1:0] ADR_FMADR  = 'h5;

  // First field lands in the highest used bit of the word
  typedef struct packed {
    adaSelT  adaSel;
    adbSelT  adbSel;
    adFuncT  adFunc;
    regSrcT  arSrc;
    logic    arLoad;
    regSrcT  arxSrc;
    logic    arxLoad;
    logic    brLoad;
    logic    brxLoad;
    mqFuncT  mqFunc;
    logic    fmWriteL;
    logic    fmWriteR;
    logic    adLong;
    logic    adxCarryIn;
    logic    inhCarry18;
    diagSelT diagSel;
  } microWordT;

  typedef struct packed {
    logic adCarryOut;
    logic adOverflow;
    logic adxCarryOut;
  } statusT;

endpackage

`default_nettype wire

// File: edpTb.sv
`timescale 1ns/10ps
`default_nettype none

module edpTb import edpPkg::*, edpRegMapPkg::*; ();

  localparam int    FM_ADR_W    = 4;
  localparam int    CLK_HALF    = 10;
  localparam int    RESET_LEN   = 5;
  localparam int    ACK_TIMEOUT = 16;
  localparam string TRACE_FILE  = "edpTrace.txt";

  logic              CLK;
  logic              FPGA_RESET;
  logic              wbCyc;
  logic              wbStb;
  logic              wbWe;
  logic [ADDR_W-1:0] wbAdr;
  word36             wbDatW;
  word36             wbDatR;
  logic              wbAck;

  int errorCount;
  int timeoutCount;
  int checkCount;
  int lineNo;

  // Trace parsing
  int                fd;
  int                readCount;
  int                fieldCount;
  string             textLine;
  logic [7:0]        op;
  logic [ADDR_W-1:0] adrRaw;
  logic [35:0]       dataRaw;

  edpTop #(.FM_ADR_W(FM_ADR_W)) UUT (
    .CLK(CLK),
    .FPGA_RESET(FPGA_RESET),
    .wbCyc(wbCyc),
    .wbStb(wbStb),
    .wbWe(wbWe),
    .wbAdr(wbAdr),
    .wbDatW(wbDatW),
    .wbDatR(wbDatR),
    .wbAck(wbAck)
  );

  always #CLK_HALF CLK = ~CLK;

  // One Wishbone classic cycle, request held until ack
  task automatic transferWord(input logic write, input logic [ADDR_W-1:0] adr,
                              input word36 datW, output word36 datR,
                              output logic acked);
    int cycles;
    @(negedge CLK);
    wbCyc  = 1'b1;
    wbStb  = 1'b1;
    wbWe   = write;
    wbAdr  = adr;
    wbDatW = datW;
    cycles = 0;
    while (wbAck !== 1'b1 && cycles < ACK_TIMEOUT) begin
      @(negedge CLK);
      cycles++;
    end
    acked = (wbAck === 1'b1);
    datR  = wbDatR;
    if (!acked) begin
      timeoutCount++;
      $display("Timeout: no ack from address %0h at trace line %0d", adr, lineNo);
    end
    wbCyc = 1'b0;
    wbStb = 1'b0;
    wbWe  = 1'b0;
  endtask

  task automatic checkWord(input string name, input word36 got, input word36 exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("[ERROR] %s: got %h, expected %h (trace line %0d)", name, got, exp, lineNo);
    end
  endtask

  task automatic checkStatus(input statusT got, input statusT exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("[ERROR] status: got %h, expected %h (trace line %0d)", got, exp, lineNo);
    end
  endtask

  task automatic replayLine(input logic [7:0] lineOp, input logic [ADDR_W-1:0] adr,
                            input word36 data);
    word36 rdData;
    logic  acked;
    case (lineOp)
      "W": begin
        transferWord(1'b1, adr, data, rdData, acked);
      end
      "R": begin
        transferWord(1'b0, adr, '0, rdData, acked);
        if (acked) begin
          checkWord("wbDatR", rdData, data);
        end
      end
      "S": begin
        transferWord(1'b0, adr, '0, rdData, acked);
        // Status flags sit in the three lowest bits
        if (acked) begin
          checkStatus(statusT'(rdData[33:35]), statusT'(data[33:35]));
        end
      end
      default: begin
        errorCount++;
        $display("Unknown operation %c at trace line %0d", lineOp, lineNo);
      end
    endcase
  endtask

  initial begin
    CLK          = 1'b0;
    FPGA_RESET   = 1'b1;
    wbCyc        = 1'b0;
    wbStb        = 1'b0;
    wbWe         = 1'b0;
    wbAdr        = '0;
    wbDatW       = '0;
    errorCount   = 0;
    timeoutCount = 0;
    checkCount   = 0;
    lineNo       = 0;

    repeat (RESET_LEN) @(posedge CLK);
    @(negedge CLK);
    FPGA_RESET = 1'b0;

    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      errorCount++;
      $display("Could not open the trace file %s", TRACE_FILE);
    end else begin
      // Stop replaying once the bus stops answering
      while (!$feof(fd) && timeoutCount == 0) begin
        readCount = $fgets(textLine, fd);
        lineNo++;
        if (readCount > 0) begin
          fieldCount = $sscanf(textLine, "%c %h %h", op, adrRaw, dataRaw);
          if (fieldCount == 3 && op != "#") begin
            replayLine(op, adrRaw, dataRaw);
          end
        end
      end
      $fclose(fd);
    end

    if (checkCount == 0) begin
      errorCount++;
      $display("No read was checked, the trace holds no reads");
    end

    $display("Checks %0d, errors %0d, timeouts %0d", checkCount, errorCount, timeoutCount);
    if (errorCount == 0 && timeoutCount == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: edpTop.f
edpPkg.sv
edpRegMapPkg.sv
edpCtlIf.sv
edpAdder.sv
edpFastMem.sv
edpRegBlock.sv
edpDatapath.sv
edpTop.sv
edpTb.sv

// File: edpTop.sv
`timescale 1ns/10ps
`default_nettype none

module edpTop import edpPkg::*, edpRegMapPkg::*; #(
  parameter int FM_ADR_W = 4
) (
  input  logic              CLK,
  input  logic              FPGA_RESET,
  input  logic              wbCyc,
  input  logic              wbStb,
  input  logic              wbWe,
  input  logic [ADDR_W-1:0] wbAdr,
  input  word36             wbDatW,
  output word36             wbDatR,
  output logic              wbAck
);

  edpCtlIf #(.FM_ADR_W(FM_ADR_W)) ctl ();

  edpRegBlock #(.FM_ADR_W(FM_ADR_W)) regBlock (
    .CLK(CLK),
    .FPGA_RESET(FPGA_RESET),
    .wbCyc(wbCyc),
    .wbStb(wbStb),
    .wbWe(wbWe),
    .wbAdr(wbAdr),
    .wbDatW(wbDatW),
    .wbDatR(wbDatR),
    .wbAck(wbAck),
    .ctl(ctl.regs)
  );

  edpDatapath #(.FM_ADR_W(FM_ADR_W)) datapath (
    .CLK(CLK),
    .FPGA_RESET(FPGA_RESET),
    .ctl(ctl.path)
  );

endmodule

`default_nettype wire

// File: edpTrace.txt
# Columns: op, address, data, all hex; W writes, R reads a word, S reads status bits
# Addresses: 0 micro, 1 data-in, 2 step, 3 diagnostic, 4 status, 5 fast memory address
# Reset values through the diagnostic mux
R 3 000000000
W 0 000400001
R 3 000000000
W 0 000400002
R 3 000000000
W 0 000400005
R 3 000000000
W 0 000400004
R 3 000000000
S 4 000000000
# AR from data-in, BR from AR, then AR loaded with AR plus BR
W 0 000408800
W 1 123456789
W 2 000000000
W 2 000000000
W 0 000418000
S 4 000000000
W 2 000000000
R 3 2468ACF12
# Two negative operands give carry out and overflow
W 1 A00000000
W 0 000408800
W 2 000000000
W 2 000000000
W 0 000400007
R 3 400000000
S 4 000000006
# ADX sum, AD plain, AD with long carry, AD with carry 18 inhibited
W 1 800030000
W 0 000409C00
W 2 000000000
W 2 000000000
W 0 000400006
R 3 000060000
W 0 000400007
R 3 000060000
W 0 000400027
R 3 000060001
S 4 000000007
W 0 00040000F
R 3 000020000
# Fast memory word 3, full write then left only then right only
W 5 000000003
W 1 000000000
W 0 000408000
W 2 000000000
W 1 FFFFFFFFF
W 0 0004080C0
W 2 000000000
W 1 000012345
W 0 000408080
W 2 000000000
W 0 000180047
R 3 FFFFC0000
W 2 000000000
R 3 FFFFD2345
# MQ load, arithmetic right shift, left shift with carry one then zero
W 0 000580102
W 2 000000000
R 3 800030000
W 0 000400302
W 2 000000000
R 3 C00018000
W 0 000C00202
W 2 000000000
R 3 800030001
W 0 000400202
W 2 000000000
R 3 000060002
# AND, OR, XOR, then the ARX4 and BRX2 sources passed through
W 0 000480007
R 3 000010000
W 0 0004C0007
R 3 800032345
W 0 000500007
R 3 800022345
W 0 000780007
R 3 000048D16
W 0 000380007
R 3 000060001
